// File: Makefile
# Verilator build and run of the binary32 add/subtract testbench.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= fp_add_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: hw/fp_add_defines.svh
/* Width and constant macros for the binary32 format.
   Include this file wherever the format widths are needed. */
`ifndef FP_ADD_DEFINES_SVH
`define FP_ADD_DEFINES_SVH

// Exponent field width.
`define FP_EXP_W 8

// Stored fraction width, without the hidden bit.
`define FP_FRAC_W 23

// Exponent bias of binary32.
`define FP_BIAS 127

// Guard, round and sticky bits below the fraction.
`define FP_GRS_W 3

// Hidden bit, fraction and GRS bits together.
`define FP_SIG_W 27

`endif

// File: hw/fp_add_pkg.sv
/* Shared types of the binary32 add/subtract pipeline: operand union, stage structs,
   operation and error enums. Blocks refer to them by scoped name. */
`include "fp_add_defines.svh"

package fp_add_pkg;

    // Field view of one binary32 word.
    typedef struct packed {
        logic                  sign;  // Sign bit.
        logic [`FP_EXP_W-1:0]  exp;   // Biased exponent.
        logic [`FP_FRAC_W-1:0] frac;  // Stored fraction.
    } fp32_fields_t;

    // Raw word for ports and the testbench, fields for the datapath.
    typedef union packed {
        logic [`FP_EXP_W+`FP_FRAC_W:0] raw;  // Whole 32 bit word.
        fp32_fields_t                  f;    // Decoded fields.
    } fp32_u;

    typedef enum logic {
        FP_ADD = 1'b0,  // a + b.
        FP_SUB = 1'b1   // a - b.
    } fp_op_e;

    typedef enum logic [2:0] {
        ERR_NONE      = 3'd0,  // Normal result.
        ERR_INVALID   = 3'd1,  // NaN produced.
        ERR_DIV_ZERO  = 3'd2,  // Reserved, never raised by add/sub.
        ERR_OVERFLOW  = 3'd3,  // Infinity produced.
        ERR_UNDERFLOW = 3'd4   // Subnormal produced.
    } fp_err_e;

    // Result of the special operand check.
    typedef struct packed {
        logic nan;       // Result is NaN.
        logic inf;       // Result is infinity.
        logic inf_sign;  // Sign of that infinity.
    } fp_special_t;

    // Rounded magnitude path result.
    typedef struct packed {
        logic                 sign;         // Result sign.
        logic [`FP_EXP_W-1:0] exp;          // Result exponent field.
        logic [`FP_SIG_W-1:0] sig_untrunc;  // Hidden bit, fraction, GRS.
        logic                 carry;        // Exponent ran out of range.
    } fp_mag_t;

    // One operation as issued into the pipeline.
    typedef struct packed {
        fp32_u  a;   // First operand.
        fp32_u  b;   // Second operand.
        fp_op_e op;  // Add or subtract.
    } fp_operands_t;

endpackage

// File: hw/fp_add_top.sv
/* Three stage binary32 add/subtract pipeline. Takes one operation per cycle with
   a valid strobe and returns the word and error code exactly three cycles later. */
module fp_add_top (
    input  logic                     clk_i,        // Pipeline clock.
    input  logic                     reset_i,      // Synchronous, active high.
    input  logic                     in_valid_i,   // Operation present.
    input  fp_add_pkg::fp_operands_t ops_i,        // Operands and op.
    output logic                     out_valid_o,  // Result present.
    output fp_add_pkg::fp32_u        result_o,     // Packed result word.
    output fp_add_pkg::fp_err_e      error_o       // Error code.
);

    fp_add_pkg::fp_operands_t s1_ops_q;      // Stage 1 operands.
    logic                     s1_valid_q;
    fp_add_pkg::fp_special_t  special_d;
    fp_add_pkg::fp_mag_t      mag_d;
    fp_add_pkg::fp_special_t  s2_special_q;  // Stage 2 results.
    fp_add_pkg::fp_mag_t      s2_mag_q;
    logic                     s2_valid_q;
    fp_add_pkg::fp32_u        result_d;
    fp_add_pkg::fp_err_e      error_d;

    // Valid bits travel beside the data.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            s1_valid_q  <= 1'b0;
            s2_valid_q  <= 1'b0;
            out_valid_o <= 1'b0;
        end else begin
            s1_valid_q  <= in_valid_i;
            s2_valid_q  <= s1_valid_q;
            out_valid_o <= s2_valid_q;
        end
    end

    // Data registers load only with a valid operation.
    always_ff @(posedge clk_i) begin
        if (in_valid_i) s1_ops_q <= ops_i;
        if (s1_valid_q) begin
            s2_special_q <= special_d;
            s2_mag_q     <= mag_d;
        end
        if (s2_valid_q) begin
            result_o <= result_d;
            error_o  <= error_d;
        end
    end

    // Both paths see the same stage 1 operands.
    fp_special_detect u_special (
        .ops_i     (s1_ops_q),
        .special_o (special_d)
    );

    fp_mag_path u_mag (
        .ops_i (s1_ops_q),
        .mag_o (mag_d)
    );

    fp_error_check u_check (
        .special_i (s2_special_q),
        .mag_i     (s2_mag_q),
        .result_o  (result_d),
        .error_o   (error_d)
    );

endmodule

// File: hw/fp_error_check.sv
/* Final combine step. Merges the special case and magnitude results into the
   packed binary32 word and picks the single error code. */
`include "fp_add_defines.svh"

module fp_error_check (
    input  fp_add_pkg::fp_special_t special_i,  // Stage 2 special decision.
    input  fp_add_pkg::fp_mag_t     mag_i,      // Stage 2 magnitude result.
    output fp_add_pkg::fp32_u       result_o,   // Packed word.
    output fp_add_pkg::fp_err_e     error_o     // Error code.
);

    logic [`FP_FRAC_W-1:0] frac_trunc;  // Fraction without hidden and round bits.
    logic                  exp_ones;
    logic                  exp_zero;

    always_comb begin
        frac_trunc = mag_i.sig_untrunc[`FP_SIG_W-2:`FP_GRS_W];
        exp_ones   = &mag_i.exp;
        exp_zero   = (mag_i.exp == '0);

        // Default packing, overridden below by priority.
        result_o.f.sign = mag_i.sign;
        result_o.f.exp  = mag_i.exp;
        result_o.f.frac = frac_trunc;

        if (special_i.nan) begin
            result_o.f.sign = 1'b0;                   // Canonical quiet NaN.
            result_o.f.exp  = '1;
            result_o.f.frac = '1;
            error_o         = fp_add_pkg::ERR_INVALID;
        end else if (special_i.inf) begin
            result_o.f.sign = special_i.inf_sign;     // Infinite operand passes through.
            result_o.f.exp  = '1;
            result_o.f.frac = '0;
            error_o         = fp_add_pkg::ERR_OVERFLOW;
        end else if (mag_i.carry || exp_ones) begin
            result_o.f.exp  = '1;                     // Rounded past largest finite.
            result_o.f.frac = '0;
            error_o         = fp_add_pkg::ERR_OVERFLOW;
        end else if (exp_zero && frac_trunc != '0) begin
            error_o         = fp_add_pkg::ERR_UNDERFLOW;  // Subnormal, word as is.
        end else begin
            error_o         = fp_add_pkg::ERR_NONE;   // Normal or exact zero.
        end
    end

endmodule

// File: hw/fp_mag_path.sv
/* Finite magnitude datapath. Aligns, adds or subtracts, normalizes and rounds
   to nearest even, producing subnormals where the exponent bottoms out. */
`include "fp_add_defines.svh"

module fp_mag_path (
    input  fp_add_pkg::fp_operands_t ops_i,  // Registered stage 1 operands.
    output fp_add_pkg::fp_mag_t      mag_o   // Rounded sign, exponent, significand.
);

    localparam int SIG_W = `FP_SIG_W;
    localparam int EXP_W = `FP_EXP_W;
    localparam int GRS_W = `FP_GRS_W;
    localparam int MAN_W = `FP_FRAC_W + 1;                   // Hidden bit and fraction.
    localparam int LZC_W = $clog2(SIG_W + 1);
    localparam logic [EXP_W:0] EXP_MAX = 2 * `FP_BIAS + 1;   // All ones exponent.

    logic             sign_a, sign_b;
    logic [EXP_W-1:0] exp_a, exp_b;      // Subnormals read as exponent 1.
    logic [SIG_W-1:0] sig_a, sig_b;
    logic             a_ge_b;            // |a| >= |b|.
    logic             sign_big, sign_sml;
    logic [EXP_W-1:0] exp_big, exp_sml, exp_diff;
    logic [SIG_W-1:0] sig_big, sig_sml;
    logic [SIG_W-1:0] sig_aln;           // Smaller operand after alignment.
    logic [SIG_W-1:0] shift_mask;        // Bits lost by the alignment shift.
    logic             sticky;
    logic             eff_sub;           // Signs differ, magnitudes subtract.
    logic [SIG_W:0]   sum;               // One extra bit for carry out.
    logic [LZC_W-1:0] lzc;
    logic [EXP_W-1:0] shamt;
    logic [SIG_W-1:0] sig_n;             // Normalized significand.
    logic [EXP_W:0]   exp_n;
    logic             round_up;
    logic [MAN_W:0]   rnd;               // Rounded mantissa with carry.
    logic [MAN_W-1:0] man_r;
    logic [EXP_W:0]   exp_r;
    logic             sign_r;

    // Unpack and order by magnitude.
    always_comb begin
        sign_a = ops_i.a.f.sign;
        sign_b = ops_i.b.f.sign ^ (ops_i.op == fp_add_pkg::FP_SUB);  // Negate b on subtract.
        exp_a  = (ops_i.a.f.exp == '0) ? EXP_W'(1) : ops_i.a.f.exp;
        exp_b  = (ops_i.b.f.exp == '0) ? EXP_W'(1) : ops_i.b.f.exp;
        sig_a  = {ops_i.a.f.exp != '0, ops_i.a.f.frac, {GRS_W{1'b0}}};  // No hidden bit if subnormal.
        sig_b  = {ops_i.b.f.exp != '0, ops_i.b.f.frac, {GRS_W{1'b0}}};

        a_ge_b   = {ops_i.a.f.exp, ops_i.a.f.frac} >= {ops_i.b.f.exp, ops_i.b.f.frac};
        sign_big = a_ge_b ? sign_a : sign_b;
        sign_sml = a_ge_b ? sign_b : sign_a;
        exp_big  = a_ge_b ? exp_a : exp_b;
        exp_sml  = a_ge_b ? exp_b : exp_a;
        sig_big  = a_ge_b ? sig_a : sig_b;
        sig_sml  = a_ge_b ? sig_b : sig_a;
    end

    // Align with sticky, then add or subtract.
    always_comb begin
        exp_diff   = exp_big - exp_sml;
        shift_mask = '0;
        if (exp_diff >= EXP_W'(SIG_W)) begin
            sig_aln = '0;                                    // Shifted fully out.
            sticky  = |sig_sml;
        end else begin
            shift_mask = (SIG_W'(1) << exp_diff) - SIG_W'(1);
            sig_aln    = sig_sml >> exp_diff;
            sticky     = |(sig_sml & shift_mask);
        end
        sig_aln[0] = sig_aln[0] | sticky;                    // Sticky folds into the LSB.

        eff_sub = sign_big ^ sign_sml;
        sum = eff_sub ? ({1'b0, sig_big} - {1'b0, sig_aln})  // Never negative, big is first.
                      : ({1'b0, sig_big} + {1'b0, sig_aln});
    end

    // Normalize, clamping at the subnormal boundary.
    always_comb begin
        lzc = LZC_W'(SIG_W);
        for (int i = 0; i < SIG_W; i++) begin
            if (sum[i]) lzc = LZC_W'(SIG_W - 1 - i);          // Highest set bit wins.
        end

        shamt = '0;
        if (sum[SIG_W]) begin
            sig_n = {sum[SIG_W:2], sum[1] | sum[0]};         // Carry out, shift right one.
            exp_n = {1'b0, exp_big} + 1'b1;
        end else if (sum == '0) begin
            sig_n = '0;                                      // Exact zero.
            exp_n = '0;
        end else if (EXP_W'(lzc) < exp_big) begin
            shamt = EXP_W'(lzc);
            sig_n = sum[SIG_W-1:0] << shamt;
            exp_n = {1'b0, exp_big - shamt};
        end else begin
            shamt = exp_big - 1'b1;                          // Stop at exponent 1.
            sig_n = sum[SIG_W-1:0] << shamt;
            exp_n = '0;                                      // Subnormal field.
        end
    end

    // Round to nearest, ties to even.
    always_comb begin
        round_up = sig_n[2] & (sig_n[1] | sig_n[0] | sig_n[GRS_W]);
        rnd      = {1'b0, sig_n[SIG_W-1:GRS_W]} + {{MAN_W{1'b0}}, round_up};

        if (rnd[MAN_W]) begin
            exp_r = exp_n + 1'b1;                            // Mantissa wrapped to 1.0.
            man_r = rnd[MAN_W:1];
        end else if (exp_n == '0 && rnd[MAN_W-1]) begin
            exp_r = (EXP_W + 1)'(1);                         // Subnormal rounded up to normal.
            man_r = rnd[MAN_W-1:0];
        end else begin
            exp_r = exp_n;
            man_r = rnd[MAN_W-1:0];
        end

        sign_r = (sum == '0 && eff_sub) ? 1'b0 : sign_big;   // x - x gives +0.
    end

    always_comb begin
        mag_o.sign        = sign_r;
        mag_o.exp         = exp_r[EXP_W-1:0];
        mag_o.sig_untrunc = {man_r, {GRS_W{1'b0}}};          // GRS consumed by rounding.
        mag_o.carry       = (exp_r >= EXP_MAX);              // Out of finite range.
    end

endmodule

// File: hw/fp_special_detect.sv
/* Special operand classifier. Flags NaN and infinity inputs so that the error
   checker can override the magnitude path result. Purely combinational. */
module fp_special_detect (
    input  fp_add_pkg::fp_operands_t ops_i,   // Registered stage 1 operands.
    output fp_add_pkg::fp_special_t  special_o // Special case decision.
);

    logic sign_a;    // Sign of a.
    logic sign_b;    // Sign of b after subtract flip.
    logic a_nan;
    logic b_nan;
    logic a_inf;
    logic b_inf;
    logic inf_clash; // Infinities of opposite sign.

    always_comb begin
        sign_a = ops_i.a.f.sign;
        sign_b = ops_i.b.f.sign ^ (ops_i.op == fp_add_pkg::FP_SUB);  // Subtract is add of -b.

        // All ones exponent, nonzero fraction is NaN, zero fraction is infinity.
        a_nan = (&ops_i.a.f.exp) & (|ops_i.a.f.frac);
        b_nan = (&ops_i.b.f.exp) & (|ops_i.b.f.frac);
        a_inf = (&ops_i.a.f.exp) & ~(|ops_i.a.f.frac);
        b_inf = (&ops_i.b.f.exp) & ~(|ops_i.b.f.frac);

        inf_clash = a_inf & b_inf & (sign_a ^ sign_b);  // +inf + -inf has no value.
    end

    always_comb begin
        special_o = '0;
        if (a_nan || b_nan || inf_clash) begin
            special_o.nan = 1'b1;                      // Invalid operation.
        end else if (a_inf || b_inf) begin
            special_o.inf      = 1'b1;                 // Infinity dominates any finite.
            special_o.inf_sign = a_inf ? sign_a : sign_b;  // Same sign if both infinite.
        end
    end

endmodule

// File: tests/fp_add_tb.sv
/* Testbench for the binary32 add/subtract pipeline. Issues directed and LFSR random
   operations and checks every result against a bit exact model. */
module fp_add_tb;

    localparam int LATENCY     = 3;     // Capture edge to result edge.
    localparam int N_DIRECTED  = 13;
    localparam int N_CYCLES    = 5000;  // Length of the random phase.
    localparam int DRAIN_LIMIT = 20;    // Edges allowed for the pipeline to empty.

    typedef struct packed {
        fp_add_pkg::fp32_u   word;  // Expected result word.
        fp_add_pkg::fp_err_e code;  // Expected error code.
    } model_t;

    typedef struct packed {
        model_t      res;
        logic [31:0] due;  // Edge count at which out_valid should show.
    } expected_t;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     in_valid;
    fp_add_pkg::fp_operands_t ops;
    logic                     out_valid;
    fp_add_pkg::fp32_u        result;
    fp_add_pkg::fp_err_e      error_code;

    logic [31:0] lfsr_q   = 32'd60;  // Seed.
    logic [31:0] edge_cnt = '0;      // Rising edges seen so far.
    expected_t   exp_q[$];           // Operations in flight.
    expected_t   head;
    int          issued       = 0;
    int          results      = 0;
    int          value_errs   = 0;
    int          latency_errs = 0;
    int          other_errs   = 0;

    always #2 clk = ~clk;  // Period 4.

    always @(posedge clk) edge_cnt <= edge_cnt + 32'd1;

    fp_add_top DUT (
        .clk_i       (clk),
        .reset_i     (reset),
        .in_valid_i  (in_valid),
        .ops_i       (ops),
        .out_valid_o (out_valid),
        .result_o    (result),
        .error_o     (error_code)
    );

    // 32 bit Fibonacci LFSR, taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);  // One step per bit.
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Bit exact add with jammed sticky, round to nearest even, error rules.
    function automatic model_t reference_add(input fp_add_pkg::fp_operands_t o);
        model_t      m;
        logic        sa, sb, a_nan, b_nan, a_inf, b_inf, eff_sub, sr;
        int          ea, eb, e_big, d, p, r, e;
        logic [63:0] ma, mb, big, sml, s, q, rem, half;
        sa    = o.a.f.sign;
        sb    = o.b.f.sign ^ (o.op == fp_add_pkg::FP_SUB);  // a - b is a + (-b).
        a_nan = (o.a.f.exp == 8'hFF) && (o.a.f.frac != 23'h0);
        b_nan = (o.b.f.exp == 8'hFF) && (o.b.f.frac != 23'h0);
        a_inf = (o.a.f.exp == 8'hFF) && (o.a.f.frac == 23'h0);
        b_inf = (o.b.f.exp == 8'hFF) && (o.b.f.frac == 23'h0);
        m.word.raw = 32'h7FFF_FFFF;                        // Canonical NaN.
        m.code     = fp_add_pkg::ERR_INVALID;
        if (a_nan || b_nan || (a_inf && b_inf && sa != sb)) return m;
        m.code = fp_add_pkg::ERR_OVERFLOW;
        if (a_inf || b_inf) begin
            m.word.raw = {(a_inf ? sa : sb), 8'hFF, 23'h0};
            return m;
        end
        // Value is sig * 2^(exp - 180), subnormals at exponent 1.
        ea      = (o.a.f.exp == 8'h00) ? 1 : int'(o.a.f.exp);
        eb      = (o.b.f.exp == 8'h00) ? 1 : int'(o.b.f.exp);
        ma      = {40'h0, (o.a.f.exp != 8'h00), o.a.f.frac} << 30;  // 30 extra bits.
        mb      = {40'h0, (o.b.f.exp != 8'h00), o.b.f.frac} << 30;
        eff_sub = sa ^ sb;
        if (eb > ea || (eb == ea && mb > ma)) begin
            big   = mb;
            sml   = ma;
            e_big = eb;
            d     = eb - ea;
            sr    = sb;
        end else begin
            big   = ma;
            sml   = mb;
            e_big = ea;
            d     = ea - eb;
            sr    = sa;
        end
        if (d > 63) begin
            sml = {63'h0, (sml != 64'h0)};                 // Whole operand is sticky.
        end else begin
            sml = (sml >> d) | {63'h0, ((sml & ((64'd1 << d) - 64'd1)) != 64'h0)};
        end
        s = eff_sub ? (big - sml) : (big + sml);
        if (s == 64'h0) begin
            m.word.raw = {(eff_sub ? 1'b0 : sa), 31'h0};   // Cancellation gives +0.
            m.code     = fp_add_pkg::ERR_NONE;
            return m;
        end
        p = 0;
        for (int i = 0; i < 64; i++) begin
            if (s[i]) p = i;
        end
        e = e_big + p - 53;  // Bit 53 holds the hidden bit at e_big.
        r = p - 23;
        if (e < 1) begin
            r = r + 1 - e;                                 // Hold the scale at exponent 1.
            e = 1;
        end
        q    = s >> r;
        rem  = s & ((64'd1 << r) - 64'd1);
        half = 64'd1 << (r - 1);
        if (rem > half || (rem == half && q[0])) q = q + 64'd1;
        if (q[24]) begin
            q = q >> 1;                                    // Rounded up to the next binade.
            e = e + 1;
        end
        if (e >= 255) begin
            m.word.raw = {sr, 8'hFF, 23'h0};
            return m;
        end
        m.word.raw = {sr, (q[23] ? 8'(e) : 8'h00), q[22:0]};
        m.code = (m.word.f.exp == 8'h00 && m.word.f.frac != 23'h0) ?
                 fp_add_pkg::ERR_UNDERFLOW : fp_add_pkg::ERR_NONE;
        return m;
    endfunction

    function automatic fp_add_pkg::fp_operands_t directed_op(input int i);
        logic [64:0] v;
        case (i)
            0:       v = {32'h3F80_0000, 32'h3F80_0000, 1'b1};  // 1 - 1.
            1:       v = {32'hBF80_0000, 32'h3F80_0000, 1'b0};  // -1 + 1.
            2:       v = {32'h7F7F_FFFF, 32'h7F7F_FFFF, 1'b0};  // Max + max.
            3:       v = {32'hFF7F_FFFF, 32'h7F7F_FFFF, 1'b1};  // -max - max.
            4:       v = {32'h7F80_0000, 32'hFF80_0000, 1'b0};  // +inf + -inf.
            5:       v = {32'h7F80_0000, 32'h7F80_0000, 1'b1};  // inf - inf.
            6:       v = {32'h7FC0_0001, 32'h3F80_0000, 1'b0};  // NaN operand.
            7:       v = {32'h3F80_0000, 32'h7F80_0000, 1'b1};  // 1 - inf.
            8:       v = {32'h0080_0001, 32'h0080_0000, 1'b1};  // Smallest subnormal.
            9:       v = {32'h0000_0003, 32'h8000_0001, 1'b0};  // Subnormal inputs.
            10:      v = {32'h3F80_0000, 32'h3380_0000, 1'b0};  // Tie, stays even.
            11:      v = {32'h8000_0000, 32'h0000_0000, 1'b1};  // -0 - +0.
            default: v = {32'h3F80_0001, 32'h3380_0000, 1'b0};  // Tie, rounds up.
        endcase
        return fp_add_pkg::fp_operands_t'(v);
    endfunction

    task automatic random_word(output fp_add_pkg::fp32_u w);
        logic [31:0] sel;
        logic [31:0] cls;
        logic [31:0] bits;
        get_bits(3, sel);
        get_bits(32, bits);
        w.raw = bits;
        if (sel[2:0] == 3'd0) begin  // About one in eight from a special class.
            get_bits(3, cls);
            case (cls[2:0])
                3'd0:    w.raw = {bits[31], 31'h0};                    // Signed zero.
                3'd1:    w.raw = {bits[31], 8'hFF, 23'h0};             // Infinity.
                3'd2:    w.raw = {bits[31], 8'hFF, bits[22:1], 1'b1};  // NaN.
                3'd3,
                3'd4:    w.raw = {bits[31], 8'h00, bits[22:0]};        // Subnormal.
                3'd5:    w.raw = {bits[31], 8'hFE, 23'h7F_FFFF};       // Largest finite.
                3'd6:    w.raw = {bits[31], 8'h01, bits[22:0]};        // Lowest binade.
                default: w.raw = {bits[31], 8'hFE, bits[22:0]};        // Top binade.
            endcase
        end
    endtask

    task automatic random_ops(output fp_add_pkg::fp_operands_t o);
        fp_add_pkg::fp32_u a;
        fp_add_pkg::fp32_u b;
        logic [31:0]       bits;
        random_word(a);
        random_word(b);
        get_bits(3, bits);
        if (bits[2:0] == 3'd0) begin
            get_bits(8, bits);
            b.raw = {bits[7], a.raw[30:0] ^ {24'h0, bits[6:0]}};  // Near copy, cancels.
        end
        get_bits(1, bits);
        o.a  = a;
        o.b  = b;
        o.op = fp_add_pkg::fp_op_e'(bits[0]);
    endtask

    task automatic issue_op(input fp_add_pkg::fp_operands_t next_ops);
        expected_t e;
        @(posedge clk);
        in_valid <= 1'b1;
        ops      <= next_ops;
        e.res     = reference_add(next_ops);
        e.due     = edge_cnt + 32'(2 + LATENCY);  // Captured next edge, count lags by one.
        exp_q.push_back(e);
        issued++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic check_word(input fp_add_pkg::fp32_u got, input fp_add_pkg::fp32_u want);
        if (got.raw !== want.raw) begin
            $display("[FAIL] %0t result %08h, expected %08h", $time, got.raw, want.raw);
            value_errs++;
        end
    endtask

    task automatic check_code(input fp_add_pkg::fp_err_e got, input fp_add_pkg::fp_err_e want);
        if (got !== want) begin
            $display("[FAIL] %0t error code %0d, expected %0d", $time, got, want);
            value_errs++;
        end
    endtask

    // Outputs are sampled mid cycle, away from the rising edge.
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("At time %0t out_valid was high with nothing in flight.", $time);
                other_errs++;
            end else begin
                head = exp_q.pop_front();
                // The next rising edge takes this result.
                if (edge_cnt + 32'd1 != head.due) begin
                    $display("At time %0t a result arrived at edge %0d instead of edge %0d.",
                             $time, edge_cnt + 32'd1, head.due);
                    latency_errs++;
                end
                check_word(result, head.res.word);
                check_code(error_code, head.res.code);
                results++;
            end
        end
    end

    initial begin
        fp_add_pkg::fp_operands_t rnd_ops;
        logic [31:0]              gap;
        int                       waited;
        reset    = 1'b1;
        in_valid = 1'b0;
        ops      = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        repeat (5) idle_cycle();  // Nothing issued, out_valid must stay low.
        for (int i = 0; i < N_DIRECTED; i++) begin
            issue_op(directed_op(i));  // Back to back.
        end
        for (int c = 0; c < N_CYCLES; c++) begin
            get_bits(2, gap);
            if (gap[1:0] == 2'd0) begin
                idle_cycle();
            end else begin
                random_ops(rnd_ops);
                issue_op(rnd_ops);
            end
        end
        idle_cycle();
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out with %0d results still outstanding.", exp_q.size());
            other_errs++;
        end
        repeat (8) @(posedge clk);  // A stray late result would show here.
        if (results != issued) begin
            $display("Issued %0d operations but saw %0d results.", issued, results);
            other_errs++;
        end
        $display("Issued %0d, results %0d, value errors %0d, latency errors %0d, other errors %0d",
                 issued, results, value_errs, latency_errs, other_errs);
        if (value_errs + latency_errs + other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+hw
hw/fp_add_pkg.sv
hw/fp_special_detect.sv
hw/fp_mag_path.sv
hw/fp_error_check.sv
hw/fp_add_top.sv
tests/fp_add_tb.sv
